// ==== fetch_stage.f ====
hdl/fetch_pkg.sv
hdl/pc_select.sv
hdl/prefetch_buffer.sv
hdl/rvc_expander.sv
hdl/fetch_stage.sv
bench/fetch_stage_assert.sv
bench/tb_fetch_stage.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the fetch stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
  --top-module tb_fetch_stage \
  -f fetch_stage.f \
  -o sim_fetch_stage
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/sim_fetch_stage > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "tests failed" "$LOG"; then
  exit 1
fi
exit 0

// ==== bench/fetch_stim.txt ====
# M addr word expected_insn illegal err  (memory image, hex)
# R pc_mux target accepted_count_before_issue  (redirect, hex)
R 0 00000102 0
M 00000100 00500093 00500093 0 0
M 00000104 ABCD450D 00300513 0 0
M 00000108 00000000 00000013 1 0
R 1 00000200 3
M 00000200 0000147D FFF40413 0 0
M 00000204 00000013 00000013 0 1
R 2 00000240 5
M 00000240 0000829A 006002B3 0 0
M 00000244 0000929A 006282B3 0 0
R 4 000002C0 7
M 00000280 00004144 00452483 0 0
M 00000284 0000C504 00952423 0 0
R 5 0000028C 9
M 0000028C 0000A021 0080006F 0 0
M 00000290 0000C011 00040263 0 0
R 3 00000104 B

// ==== bench/tb_fetch_stage.sv ====
// Testbench for the fetch stage with bus memory model, scoreboard, timeout and report

module tb_fetch_stage import fetch_pkg::*; ();

  logic        clk;
  logic        rst_n;
  ctrl_fsm_t   ctrl_fsm;
  pc_targets_t targets;
  logic        trigger_match;
  logic        instr_req;
  addr_t       instr_addr;
  logic        instr_gnt;
  logic        instr_rvalid;
  fetch_resp_t instr_resp;
  if_id_pipe_t pipe;
  addr_t       pc_if;
  logic        mtvec_init;
  logic        if_busy;
  logic        if_valid;
  logic        abort_op;
  logic        id_ready;

  // Memory image and expected results, keyed by word address
  insn_t       mem_word [addr_t];
  insn_t       exp_insn [addr_t];
  logic        exp_ill [addr_t];
  logic        exp_err [addr_t];
  // Pending redirects in issue order
  int          rd_mux [$];
  addr_t       rd_target [$];
  int          rd_idx [$];
  // Bus fetches in flight with their remaining delay
  addr_t       bus_addr [$];
  int          bus_delay [$];

  int          fails [6];
  int          checks;
  int          accepted;
  int          n_lines;
  int          pulses;
  addr_t       exp_pc;
  int          last_mux;
  logic        after_redirect;
  logic        took;
  logic        took_trig;
  logic        stalled;
  if_id_pipe_t pipe_snap;

  fetch_stage dut0 (
    .clk              (clk),
    .rst_n            (rst_n),
    .ctrl_fsm_i       (ctrl_fsm),
    .targets_i        (targets),
    .trigger_match_i  (trigger_match),
    .instr_req_o      (instr_req),
    .instr_addr_o     (instr_addr),
    .instr_gnt_i      (instr_gnt),
    .instr_rvalid_i   (instr_rvalid),
    .instr_resp_i     (instr_resp),
    .if_id_pipe_o     (pipe),
    .pc_if_o          (pc_if),
    .csr_mtvec_init_o (mtvec_init),
    .if_busy_o        (if_busy),
    .if_valid_o       (if_valid),
    .abort_op_o       (abort_op),
    .id_ready_i       (id_ready)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  task automatic compare(input string sig, input logic [95:0] got, input logic [95:0] exp,
                         input int test);
    checks++;
    if (got !== exp) begin
      $display("MISMATCH t=%0t %s got %h exp %h", $time, sig, got, exp);
      fails[test]++;
    end
  endtask

  // Fetch target by the PC source rules
  function automatic addr_t redirect_target(input int mux, input addr_t t);
    case (mux)
      0:       return {t[31:2], 2'b00};
      4:       return {t[31:7], 7'b000_0000};
      5:       return {t[31:7], t[6:2], 2'b00};
      default: return t;
    endcase
  endfunction

  task automatic load_stim();
    int    fd;
    int    n;
    string line;
    string kind;
    logic [31:0] f1, f2, f3, f4, f5;
    fd = $fopen("bench/fetch_stim.txt", "r");
    if (fd == 0) begin
      $display("cannot open the stimulus file");
      fails[0]++;
    end else begin
      while (!$feof(fd)) begin
        n = $fgets(line, fd);
        if (n == 0 || line.len() < 2 || line.substr(0, 0) == "#") begin
          continue;
        end
        n = $sscanf(line, "%s %h %h %h %h %h", kind, f1, f2, f3, f4, f5);
        n_lines++;
        if (kind == "M") begin
          mem_word[f1] = f2;
          exp_insn[f1] = f3;
          exp_ill[f1]  = f4[0];
          exp_err[f1]  = f5[0];
        end else begin
          rd_mux.push_back(int'(f1));
          rd_target.push_back(f2);
          rd_idx.push_back(int'(f3));
        end
      end
      $fclose(fd);
    end
  endtask

  // Item captured at the last edge against the scoreboard
  task automatic check_item();
    insn_t raw;
    int    pc_test;
    pc_test = after_redirect ? ((last_mux == 0) ? 0 : 3) : 4;
    compare("if_id_pipe_o.pc", 96'(pipe.pc), 96'(exp_pc), pc_test);
    compare("if_id_pipe_o.instr_valid", 96'(pipe.instr_valid), 96'd1, 4);
    after_redirect = 1'b0;
    if (!mem_word.exists(exp_pc)) begin
      $display("item accepted from an address outside the memory image");
      fails[4]++;
    end else begin
      raw = mem_word[exp_pc];
      compare("if_id_pipe_o.instr", 96'(pipe.instr), 96'(exp_insn[exp_pc]),
              exp_ill[exp_pc] ? 2 : 1);
      compare("if_id_pipe_o.compressed", 96'(pipe.compressed), 96'(raw[1:0] != 2'b11), 1);
      compare("if_id_pipe_o.illegal_c_insn", 96'(pipe.illegal_c_insn),
              96'(exp_ill[exp_pc]), 2);
      if (raw[1:0] != 2'b11) begin
        compare("if_id_pipe_o.compressed_instr", 96'(pipe.compressed_instr),
                96'(raw[15:0]), 1);
      end
      compare("if_id_pipe_o.bus_err", 96'(pipe.bus_err), 96'(exp_err[exp_pc]), 5);
      compare("if_id_pipe_o.trigger_match", 96'(pipe.trigger_match), 96'(took_trig), 5);
      compare("if_id_pipe_o.abort_op", 96'(pipe.abort_op),
              96'(exp_err[exp_pc] || took_trig), 5);
    end
    exp_pc   = exp_pc + 32'd4;
    accepted++;
  endtask

  // In-order bus responder with random grant and delay
  task automatic drive_bus();
    addr_t a;
    instr_rvalid = 1'b0;
    instr_resp   = '0;
    if (bus_addr.size() > 0) begin
      if (bus_delay[0] == 0) begin
        a = bus_addr.pop_front();
        void'(bus_delay.pop_front());
        instr_rvalid     = 1'b1;
        instr_resp.rdata = mem_word.exists(a) ? mem_word[a] : RVC_NOP_INSN;
        instr_resp.err   = exp_err.exists(a) ? exp_err[a] : 1'b0;
      end else begin
        bus_delay[0] = bus_delay[0] - 1;
      end
    end
    instr_gnt = ($urandom % 4) != 0;
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin : main
    string names [6];
    int    cycles;
    int    limit;
    int    total;
    logic  done;
    logic  timed_out;
    logic  boot_now;
    logic  offered_err;
    void'($urandom(44));
    names = '{"boot", "expansion", "illegal", "redirect", "backpressure", "abort"};
    rst_n = 1'b0;
    ctrl_fsm = '0;
    targets = '0;
    trigger_match = 1'b0;
    instr_gnt = 1'b0;
    instr_rvalid = 1'b0;
    instr_resp = '0;
    id_ready = 1'b0;
    took = 1'b0;
    stalled = 1'b0;
    done = 1'b0;
    timed_out = 1'b0;
    cycles = 0;
    load_stim();
    limit = 40 * n_lines;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    while (!done) begin
      @(negedge clk);
      cycles++;
      if (cycles > limit) begin
        $display("timeout after %0d cycles with %0d items accepted", cycles, accepted);
        timed_out = 1'b1;
        break;
      end
      if (took) begin
        check_item();
      end else if (stalled) begin
        compare("if_id_pipe_o", 96'(pipe), 96'(pipe_snap), 4);
      end
      drive_bus();
      ctrl_fsm.pc_set  = 1'b0;
      ctrl_fsm.kill_if = 1'b0;
      boot_now = 1'b0;
      if (rd_idx.size() > 0 && accepted == rd_idx[0]) begin
        // Redirect kills whatever the stage still holds
        last_mux = rd_mux.pop_front();
        targets.boot_addr     = rd_target[0];
        targets.jump_target   = rd_target[0];
        targets.branch_target = rd_target[0];
        targets.mepc          = rd_target[0];
        targets.mtvec_base    = rd_target[0][31:7];
        ctrl_fsm.irq_id  = rd_target[0][6:2];
        ctrl_fsm.pc_mux  = pc_mux_e'(last_mux);
        ctrl_fsm.pc_set  = 1'b1;
        ctrl_fsm.kill_if = 1'b1;
        boot_now = (last_mux == 0);
        exp_pc = redirect_target(last_mux, rd_target.pop_front());
        void'(rd_idx.pop_front());
        after_redirect = 1'b1;
      end else if (rd_idx.size() == 0 && !mem_word.exists(exp_pc)) begin
        done = 1'b1;
      end
      id_ready      = ($urandom % 4) != 0;
      trigger_match = ($urandom % 8) == 0;
      #1;
      compare("csr_mtvec_init_o", 96'(mtvec_init), 96'(boot_now), 0);
      if (mtvec_init) begin
        pulses++;
      end
      // A response on the bus this cycle is still counted by the DUT
      compare("if_busy_o", 96'(if_busy), 96'((bus_addr.size() > 0) || instr_rvalid), 4);
      if (ctrl_fsm.kill_if) begin
        compare("if_valid_o", 96'(if_valid), 96'd0, 3);
      end else if (if_valid) begin
        // Offered item is the next one the scoreboard expects
        offered_err = exp_err.exists(exp_pc) ? exp_err[exp_pc] : 1'b0;
        compare("pc_if_o", 96'(pc_if), 96'(exp_pc), 4);
        compare("abort_op_o", 96'(abort_op), 96'(offered_err || trigger_match), 5);
      end
      if (instr_req && instr_gnt) begin
        bus_addr.push_back(instr_addr);
        bus_delay.push_back(int'($urandom % 4));
      end
      took      = if_valid && id_ready;
      took_trig = trigger_match;
      stalled   = !id_ready;
      pipe_snap = pipe;
    end
    compare("mtvec init pulse count", 96'(pulses), 96'd1, 0);

    total = 0;
    foreach (names[i]) begin
      $display("test %-12s %s (%0d errors)", names[i], (fails[i] == 0) ? "PASS" : "FAIL",
               fails[i]);
      total += fails[i];
    end
    $display("checks %0d, items %0d, errors %0d", checks, accepted, total);
    if (total == 0 && !timed_out) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// ==== bench/fetch_stage_assert.sv ====
// Concurrent assertions on bus protocol, fetch depth, IF/ID hold and mtvec init

module fetch_stage_assert import fetch_pkg::*; (
  input logic        clk,
  input logic        rst_n,
  input ctrl_fsm_t   ctrl_fsm_i,
  input logic        instr_req_o,
  input addr_t       instr_addr_o,
  input logic        instr_gnt_i,
  input logic        instr_rvalid_i,
  input logic        id_ready_i,
  input logic        csr_mtvec_init_o,
  input if_id_pipe_t if_id_pipe_o
);

  // Fetches accepted but not yet answered
  int out_cnt;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_cnt <= 0;
    end else begin
      out_cnt <= out_cnt + int'(instr_req_o && instr_gnt_i) - int'(instr_rvalid_i);
    end
  end

  ////////////////////////////////////////////////////////////
  // Properties
  ////////////////////////////////////////////////////////////

  a_depth : assert property (@(posedge clk) disable iff (!rst_n) out_cnt <= FETCH_DEPTH)
    else $error("more than FETCH_DEPTH fetches outstanding");

  // A redirect may steer a waiting request elsewhere
  a_addr_stable : assert property (@(posedge clk) disable iff (!rst_n)
    instr_req_o && !instr_gnt_i |=> ctrl_fsm_i.pc_set || $stable(instr_addr_o))
    else $error("instr_addr_o changed while waiting for grant");

  a_pipe_hold : assert property (@(posedge clk) disable iff (!rst_n)
    !id_ready_i |=> $stable(if_id_pipe_o))
    else $error("if_id_pipe_o changed while id_ready_i low");

  a_mtvec : assert property (@(posedge clk) disable iff (!rst_n)
    csr_mtvec_init_o |-> ctrl_fsm_i.pc_set)
    else $error("csr_mtvec_init_o without pc_set");

endmodule

bind fetch_stage fetch_stage_assert assert0 (
  .clk              (clk),
  .rst_n            (rst_n),
  .ctrl_fsm_i       (ctrl_fsm_i),
  .instr_req_o      (instr_req_o),
  .instr_addr_o     (instr_addr_o),
  .instr_gnt_i      (instr_gnt_i),
  .instr_rvalid_i   (instr_rvalid_i),
  .id_ready_i       (id_ready_i),
  .csr_mtvec_init_o (csr_mtvec_init_o),
  .if_id_pipe_o     (if_id_pipe_o)
);

// ==== hdl/fetch_stage.sv ====
// Fetch stage top with PC select, prefetch buffer, RVC expander and IF/ID register

module fetch_stage import fetch_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  ctrl_fsm_t   ctrl_fsm_i,
  input  pc_targets_t targets_i,
  input  logic        trigger_match_i,
  // Instruction bus
  output logic        instr_req_o,
  output addr_t       instr_addr_o,
  input  logic        instr_gnt_i,
  input  logic        instr_rvalid_i,
  input  fetch_resp_t instr_resp_i,
  // Towards decode
  output if_id_pipe_t if_id_pipe_o,
  output addr_t       pc_if_o,
  output logic        csr_mtvec_init_o,
  output logic        if_busy_o,
  output logic        if_valid_o,
  output logic        abort_op_o,
  input  logic        id_ready_i
);

  addr_t       branch_addr;
  fetch_item_t item;
  logic        item_valid;
  logic        item_ready;
  insn_t       instr_expanded;
  logic        instr_compressed;
  logic        illegal_c_insn;

  pc_select pc_select0 (
    .ctrl_fsm_i       (ctrl_fsm_i),
    .targets_i        (targets_i),
    .branch_addr_o    (branch_addr),
    .csr_mtvec_init_o (csr_mtvec_init_o)
  );

  prefetch_buffer prefetch_buffer0 (
    .clk            (clk),
    .rst_n          (rst_n),
    .ctrl_fsm_i     (ctrl_fsm_i),
    .branch_addr_i  (branch_addr),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_resp_i   (instr_resp_i),
    .item_valid_o   (item_valid),
    .item_o         (item),
    .item_ready_i   (item_ready),
    .busy_o         (if_busy_o)
  );

  rvc_expander rvc_expander0 (
    .instr_i         (item.resp.rdata),
    .instr_o         (instr_expanded),
    .is_compressed_o (instr_compressed),
    .illegal_o       (illegal_c_insn)
  );

  ////////////////////////////////////////////////////////////
  // Stage handshake
  ////////////////////////////////////////////////////////////

  // Nothing is offered while killed or halted
  assign if_valid_o = item_valid && !ctrl_fsm_i.kill_if && !ctrl_fsm_i.halt_if;
  // Kill drains the buffer regardless of decode
  assign item_ready = ctrl_fsm_i.kill_if || (id_ready_i && !ctrl_fsm_i.halt_if);
  assign pc_if_o    = item.pc;
  assign abort_op_o = item.resp.err || trigger_match_i;

  ////////////////////////////////////////////////////////////
  // IF/ID register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      if_id_pipe_o <= '0;
    end else if (if_valid_o && id_ready_i) begin
      if_id_pipe_o.instr_valid    <= 1'b1;
      if_id_pipe_o.instr          <= instr_expanded;
      if_id_pipe_o.pc             <= item.pc;
      if_id_pipe_o.compressed     <= instr_compressed;
      if_id_pipe_o.illegal_c_insn <= illegal_c_insn;
      if_id_pipe_o.bus_err        <= item.resp.err;
      if_id_pipe_o.trigger_match  <= trigger_match_i;
      if_id_pipe_o.abort_op       <= abort_op_o;
      // Raw halfword kept for the illegal instruction CSR value
      if (instr_compressed) begin
        if_id_pipe_o.compressed_instr <= item.resp.rdata[15:0];
      end
    end else if (id_ready_i) begin
      // Decode took the previous one and nothing replaces it
      if_id_pipe_o.instr_valid <= 1'b0;
    end
  end

endmodule

// ==== hdl/rvc_expander.sv ====
// Compressed instruction expander for a small RVC subset, with illegal detection

module rvc_expander import fetch_pkg::*; (
  input  insn_t instr_i,
  output insn_t instr_o,
  output logic  is_compressed_o,
  output logic  illegal_o
);

  cinsn_t c;

  // Only the low halfword matters for compressed words
  assign c               = instr_i[15:0];
  assign is_compressed_o = (instr_i[1:0] != 2'b11);

  ////////////////////////////////////////////////////////////
  // Expansion
  ////////////////////////////////////////////////////////////

  always_comb begin
    // Full width words go through untouched
    instr_o   = instr_i;
    illegal_o = 1'b0;
    if (is_compressed_o) begin
      // Anything not matched below stays a NOP and flagged
      instr_o   = RVC_NOP_INSN;
      illegal_o = 1'b1;
      unique case ({c[1:0], c[15:13]})
        // C.LW
        5'b00_010: begin
          instr_o   = {5'b0, c[5], c[12:10], c[6], 2'b00, 2'b01, c[9:7], 3'b010,
                       2'b01, c[4:2], 7'b0000011};
          illegal_o = 1'b0;
        end
        // C.SW
        5'b00_110: begin
          instr_o   = {5'b0, c[5], c[12], 2'b01, c[4:2], 2'b01, c[9:7], 3'b010,
                       c[11:10], c[6], 2'b00, 7'b0100011};
          illegal_o = 1'b0;
        end
        // C.ADDI, rd is also the source
        5'b01_000: begin
          instr_o   = {{7{c[12]}}, c[6:2], c[11:7], 3'b000, c[11:7], 7'b0010011};
          illegal_o = 1'b0;
        end
        // C.LI as addi from x0
        5'b01_010: begin
          instr_o   = {{7{c[12]}}, c[6:2], 5'b0, 3'b000, c[11:7], 7'b0010011};
          illegal_o = 1'b0;
        end
        // C.LUI, zero immediate and rd x2 are outside the subset
        5'b01_011: begin
          if (({c[12], c[6:2]} != 6'b0) && (c[11:7] != 5'd2)) begin
            instr_o   = {{15{c[12]}}, c[6:2], c[11:7], 7'b0110111};
            illegal_o = 1'b0;
          end
        end
        // C.J as jal x0
        5'b01_101: begin
          instr_o   = {c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3],
                       c[12], {8{c[12]}}, 5'b0, 7'b1101111};
          illegal_o = 1'b0;
        end
        // C.BEQZ and C.BNEZ, funct3 low bit picks beq or bne
        5'b01_110, 5'b01_111: begin
          instr_o   = {c[12], {3{c[12]}}, c[6:5], c[2], 5'b0, 2'b01, c[9:7],
                       2'b00, c[13], c[11:10], c[4:3], c[12], 7'b1100011};
          illegal_o = 1'b0;
        end
        // C.MV and C.ADD, rs2 of zero would be a jump or ebreak
        5'b10_100: begin
          if (c[6:2] != 5'b0) begin
            if (c[12]) begin
              instr_o = {7'b0, c[6:2], c[11:7], 3'b000, c[11:7], 7'b0110011};
            end else begin
              instr_o = {7'b0, c[6:2], 5'b0, 3'b000, c[11:7], 7'b0110011};
            end
            illegal_o = 1'b0;
          end
        end
        default: begin
          instr_o   = RVC_NOP_INSN;
          illegal_o = 1'b1;
        end
      endcase
    end
  end

endmodule

// ==== hdl/prefetch_buffer.sv ====
// Fetch address counter, bus request issue, in-flight and discard tracking, response FIFO

module prefetch_buffer import fetch_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  ctrl_fsm_t   ctrl_fsm_i,
  input  addr_t       branch_addr_i,
  // Instruction bus
  output logic        instr_req_o,
  output addr_t       instr_addr_o,
  input  logic        instr_gnt_i,
  input  logic        instr_rvalid_i,
  input  fetch_resp_t instr_resp_i,
  // Item output towards the top
  output logic        item_valid_o,
  output fetch_item_t item_o,
  input  logic        item_ready_i,
  output logic        busy_o
);

  logic                           fetch_en_q;
  addr_t                          fetch_addr_q;
  addr_t                          target_addr;
  addr_t                          resp_pc_q;
  fetch_cnt_t                     out_cnt_q;
  fetch_cnt_t                     discard_cnt_q;
  fetch_cnt_t                     fifo_cnt_q;
  fetch_cnt_t                     fifo_level;
  fetch_cnt_t                     slots_used;
  logic [$clog2(FETCH_DEPTH)-1:0] rd_ptr_q;
  logic [$clog2(FETCH_DEPTH)-1:0] wr_ptr_q;
  fetch_item_t                    fifo_q [FETCH_DEPTH];
  fetch_item_t                    push_item;
  logic                           flush;
  logic                           accept;
  logic                           resp_live;
  logic                           push;
  logic                           pop;

  ////////////////////////////////////////////////////////////
  // Request side
  ////////////////////////////////////////////////////////////

  assign target_addr = {branch_addr_i[XLEN-1:2], 2'b00};
  assign flush       = ctrl_fsm_i.pc_set || ctrl_fsm_i.kill_if;

  // FIFO counts as empty in a flush cycle
  assign fifo_level = flush ? '0 : fifo_cnt_q;
  assign slots_used = out_cnt_q + fifo_level;

  // Redirect steers the address in the same cycle
  assign instr_addr_o = ctrl_fsm_i.pc_set ? target_addr : fetch_addr_q;
  // Every fetch in flight has a FIFO slot waiting for it
  assign instr_req_o  = (fetch_en_q || ctrl_fsm_i.pc_set) && (slots_used < FETCH_DEPTH);
  assign accept       = instr_req_o && instr_gnt_i;

  // Responses to fetches from before a redirect are dropped
  assign resp_live = instr_rvalid_i && (discard_cnt_q == '0) && !ctrl_fsm_i.pc_set;
  assign push      = resp_live && !ctrl_fsm_i.kill_if;
  assign pop       = item_valid_o && item_ready_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fetch_en_q    <= 1'b0;
      fetch_addr_q  <= '0;
      resp_pc_q     <= '0;
      out_cnt_q     <= '0;
      discard_cnt_q <= '0;
    end else begin
      out_cnt_q <= out_cnt_q + fetch_cnt_t'(accept) - fetch_cnt_t'(instr_rvalid_i);
      if (ctrl_fsm_i.pc_set) begin
        fetch_en_q    <= 1'b1;
        fetch_addr_q  <= accept ? target_addr + addr_t'(4) : target_addr;
        resp_pc_q     <= target_addr;
        // Whatever is still in flight after this cycle belongs to the old stream
        discard_cnt_q <= out_cnt_q - fetch_cnt_t'(instr_rvalid_i);
      end else begin
        if (accept) begin
          fetch_addr_q <= fetch_addr_q + addr_t'(4);
        end
        if (resp_live) begin
          resp_pc_q <= resp_pc_q + addr_t'(4);
        end
        if (instr_rvalid_i && (discard_cnt_q != '0)) begin
          discard_cnt_q <= discard_cnt_q - fetch_cnt_t'(1);
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Response FIFO
  ////////////////////////////////////////////////////////////

  assign push_item.resp = instr_resp_i;
  assign push_item.pc   = resp_pc_q;

  always_ff @(posedge clk) begin
    if (push) begin
      fifo_q[wr_ptr_q] <= push_item;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_ptr_q   <= '0;
      wr_ptr_q   <= '0;
      fifo_cnt_q <= '0;
    end else if (flush) begin
      rd_ptr_q   <= '0;
      wr_ptr_q   <= '0;
      fifo_cnt_q <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      fifo_cnt_q <= fifo_cnt_q + fetch_cnt_t'(push) - fetch_cnt_t'(pop);
    end
  end

  assign item_valid_o = (fifo_cnt_q != '0);
  assign item_o       = fifo_q[rd_ptr_q];
  assign busy_o       = (out_cnt_q != '0);

endmodule

// ==== hdl/pc_select.sv ====
// Next fetch address multiplexer and mtvec init pulse

module pc_select import fetch_pkg::*; (
  input  ctrl_fsm_t   ctrl_fsm_i,
  input  pc_targets_t targets_i,
  output addr_t       branch_addr_o,
  output logic        csr_mtvec_init_o
);

  ////////////////////////////////////////////////////////////
  // Target selection
  ////////////////////////////////////////////////////////////

  always_comb begin
    // Boot target doubles as the fallback
    branch_addr_o = {targets_i.boot_addr[XLEN-1:2], 2'b00};
    unique case (ctrl_fsm_i.pc_mux)
      PC_BOOT: begin
        branch_addr_o = {targets_i.boot_addr[XLEN-1:2], 2'b00};
      end
      PC_JUMP: begin
        branch_addr_o = targets_i.jump_target;
      end
      PC_BRANCH: begin
        branch_addr_o = targets_i.branch_target;
      end
      // Return from trap restores the saved PC
      PC_MRET: begin
        branch_addr_o = targets_i.mepc;
      end
      // Exceptions share the base of the vector table
      PC_TRAP_EXC: begin
        branch_addr_o = {targets_i.mtvec_base, 7'b000_0000};
      end
      // Interrupts land on their own word in the table
      PC_TRAP_IRQ: begin
        branch_addr_o = {targets_i.mtvec_base, ctrl_fsm_i.irq_id, 2'b00};
      end
      default: begin
        branch_addr_o = {targets_i.boot_addr[XLEN-1:2], 2'b00};
      end
    endcase
  end

  // CSR file loads mtvec when the core boots
  assign csr_mtvec_init_o = ctrl_fsm_i.pc_set && (ctrl_fsm_i.pc_mux == PC_BOOT);

endmodule

// ==== hdl/fetch_pkg.sv ====
// Shared widths, vector types, PC source enum and fetch structs for the fetch stage

package fetch_pkg;

  ////////////////////////////////////////////////////////////
  // Widths and sizes
  ////////////////////////////////////////////////////////////

  localparam int XLEN             = 32;
  // Response FIFO entries, also the cap on fetches in flight
  localparam int FETCH_DEPTH      = 2;
  // Counters must reach FETCH_DEPTH itself
  localparam int FETCH_CNT_WIDTH  = $clog2(FETCH_DEPTH + 1);
  localparam int MTVEC_BASE_WIDTH = 25;
  localparam int IRQ_ID_WIDTH     = 5;

  ////////////////////////////////////////////////////////////
  // Vector types
  ////////////////////////////////////////////////////////////

  typedef logic [XLEN-1:0]             addr_t;
  typedef logic [31:0]                 insn_t;
  typedef logic [15:0]                 cinsn_t;
  typedef logic [MTVEC_BASE_WIDTH-1:0] mtvec_base_t;
  typedef logic [IRQ_ID_WIDTH-1:0]     irq_id_t;
  typedef logic [FETCH_CNT_WIDTH-1:0]  fetch_cnt_t;

  // addi x0, x0, 0
  localparam insn_t RVC_NOP_INSN = 32'h0000_0013;

  // Sources for the next fetch address
  typedef enum logic [2:0] {
    PC_BOOT,
    PC_JUMP,
    PC_BRANCH,
    PC_MRET,
    PC_TRAP_EXC,
    PC_TRAP_IRQ
  } pc_mux_e;

  ////////////////////////////////////////////////////////////
  // Grouped signals
  ////////////////////////////////////////////////////////////

  // Controller commands to the fetch stage
  typedef struct packed {
    logic    pc_set;
    pc_mux_e pc_mux;
    logic    kill_if;
    logic    halt_if;
    irq_id_t irq_id;
  } ctrl_fsm_t;

  typedef struct packed {
    addr_t       boot_addr;
    addr_t       jump_target;
    addr_t       branch_target;
    addr_t       mepc;
    mtvec_base_t mtvec_base;
  } pc_targets_t;

  // One bus response
  typedef struct packed {
    insn_t rdata;
    logic  err;
  } fetch_resp_t;

  // Response paired with the address it came from
  typedef struct packed {
    fetch_resp_t resp;
    addr_t       pc;
  } fetch_item_t;

  typedef struct packed {
    logic   instr_valid;
    insn_t  instr;
    addr_t  pc;
    logic   compressed;
    logic   illegal_c_insn;
    cinsn_t compressed_instr;
    logic   bus_err;
    logic   trigger_match;
    logic   abort_op;
  } if_id_pipe_t;

endpackage
